/* flist.f */
+incdir+logic
logic/dac_pkg.sv
logic/pcm_formatter.sv
logic/sample_fifo.sv
logic/sigma_delta_dac.sv
logic/audio_dac_top.sv
test/audio_dac_tb.sv

/* logic/audio_dac_top.sv */
// ======================================================================
// Audio DAC top level
// Stereo PCM stream in, two pulse-density outputs out.
// Formatter, sample FIFO and delta-sigma consumer in a chain
// ======================================================================

module audio_dac_top #(
    parameter bit SIGNED_SND = 1'b0
) (
    input  logic                clk_dac,
    input  logic                rst,
    input  dac_pkg::pcm_pair_t  sample_i,
    input  logic                sample_valid_i,
    output logic                sample_ready_o,
    output logic                snd_pwm_left_o,
    output logic                snd_pwm_right_o
);

    // Formatter to FIFO
    dac_pkg::dac_pair_t fmt_word;
    logic               fmt_valid;
    logic               fmt_ready;

    // FIFO to consumer
    dac_pkg::dac_pair_t fifo_word;
    logic               fifo_valid;
    logic               fifo_ready;

    pcm_formatter #(
        .SIGNED_SND   ( SIGNED_SND     )
    ) u_formatter (
        .clk_dac      ( clk_dac        ),
        .rst          ( rst            ),
        .pcm_i        ( sample_i       ),
        .pcm_valid_i  ( sample_valid_i ),
        .pcm_ready_o  ( sample_ready_o ),
        .word_o       ( fmt_word       ),
        .word_valid_o ( fmt_valid      ),
        .word_ready_i ( fmt_ready      )
    );

    sample_fifo u_fifo (
        .clk_dac      ( clk_dac        ),
        .rst          ( rst            ),
        .wr_data_i    ( fmt_word       ),
        .wr_valid_i   ( fmt_valid      ),
        .wr_ready_o   ( fmt_ready      ),
        .rd_data_o    ( fifo_word      ),
        .rd_valid_o   ( fifo_valid     ),
        .rd_ready_i   ( fifo_ready     )
    );

    sigma_delta_dac u_dac (
        .clk_dac      ( clk_dac         ),
        .rst          ( rst             ),
        .word_i       ( fifo_word       ),
        .word_valid_i ( fifo_valid      ),
        .word_ready_o ( fifo_ready      ),
        .pwm_left_o   ( snd_pwm_left_o  ),
        .pwm_right_o  ( snd_pwm_right_o )
    );

endmodule

/* logic/dac_macros.svh */
// ======================================================================
// Audio DAC build constants
// Sample widths, buffer depth and modulator timing shared by the
// formatter, the sample FIFO and the delta-sigma consumer
// ======================================================================

`ifndef DAC_MACROS_SVH
`define DAC_MACROS_SVH

// Raw PCM sample width per channel
`define PCM_W 16

// Padded word fed to the modulators
`define DAC_W 20

// Entries in the sample FIFO
`define FIFO_DEPTH 4

// clk_dac cycles between modulator ticks
`define CEN_PERIOD 4

// Modulator ticks spent on each sample
`define HOLD_TICKS 16

`endif

/* logic/dac_pkg.sv */
// ======================================================================
// Audio DAC types
// Stereo sample structs for the input stream and the padded DAC words,
// plus the state encoding of the delta-sigma consumer
// ======================================================================

`include "dac_macros.svh"

package dac_pkg;

    // Raw stereo PCM as it arrives on the input stream
    typedef struct packed {
        logic [`PCM_W-1:0] left;
        logic [`PCM_W-1:0] right;
    } pcm_pair_t;

    // Offset binary words, padded for the modulators
    typedef struct packed {
        logic [`DAC_W-1:0] left;
        logic [`DAC_W-1:0] right;
    } dac_pair_t;

    // Consumer state
    typedef enum logic {
        DAC_IDLE,
        DAC_RUN
    } dac_state_e;

endpackage

/* logic/pcm_formatter.sv */
// ======================================================================
// PCM formatter
// Turns raw stereo samples into offset binary DAC words, padded with
// one zero above and zeros below, behind a one-entry output register
// ======================================================================

`include "dac_macros.svh"

module pcm_formatter #(
    parameter bit SIGNED_SND = 1'b0
) (
    input  logic                clk_dac,
    input  logic                rst,
    input  dac_pkg::pcm_pair_t  pcm_i,
    input  logic                pcm_valid_i,
    output logic                pcm_ready_o,
    output dac_pkg::dac_pair_t  word_o,
    output logic                word_valid_o,
    input  logic                word_ready_i
);

    localparam int PCM_N   = `PCM_W;
    localparam int DAC_N   = `DAC_W;
    // Zero bits below the sample, one guard bit sits above
    localparam int LOW_PAD = DAC_N - PCM_N - 1;

    // Sign flip for signed input, then pad to the DAC width
    function automatic logic [DAC_N-1:0] pad_sample(input logic [PCM_N-1:0] snd);
        logic top_bit;
        top_bit    = snd[PCM_N-1] ^ SIGNED_SND;
        pad_sample = {1'b0, top_bit, snd[PCM_N-2:0], {LOW_PAD{1'b0}}};
    endfunction

    logic accept;

    // Room when empty or when the held word leaves this cycle
    assign pcm_ready_o = !word_valid_o || word_ready_i;
    assign accept      = pcm_valid_i && pcm_ready_o;

    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            word_valid_o <= 1'b0;
        end else if (accept) begin
            word_valid_o <= 1'b1;
        end else if (word_ready_i) begin
            word_valid_o <= 1'b0;
        end
    end

    // Output payload
    always_ff @(posedge clk_dac) begin
        if (accept) begin
            word_o.left  <= pad_sample(pcm_i.left);
            word_o.right <= pad_sample(pcm_i.right);
        end
    end

endmodule

/* logic/sample_fifo.sv */
// ======================================================================
// Sample FIFO
// Circular buffer of stereo DAC words between formatter and consumer.
// Accepts and delivers on the same edge, even when full
// ======================================================================

`include "dac_macros.svh"

module sample_fifo (
    input  logic                clk_dac,
    input  logic                rst,
    input  dac_pkg::dac_pair_t  wr_data_i,
    input  logic                wr_valid_i,
    output logic                wr_ready_o,
    output dac_pkg::dac_pair_t  rd_data_o,
    output logic                rd_valid_o,
    input  logic                rd_ready_i
);

    localparam int DEPTH = `FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);
    localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(DEPTH);

    dac_pkg::dac_pair_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             push;
    logic             pop;

    // Pointer advance with wrap for any depth
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        next_ptr = (ptr == PTR_LAST) ? '0 : ptr + 1'b1;
    endfunction

    assign full       = (count == CNT_FULL);
    assign rd_valid_o = (count != '0);
    assign rd_data_o  = mem[rd_ptr];

    // A full FIFO still takes a word if the head leaves this cycle
    assign wr_ready_o = !full || rd_ready_i;

    assign push = wr_valid_i && wr_ready_o;
    assign pop  = rd_valid_o && rd_ready_i;

    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk_dac) begin
        if (push) begin
            mem[wr_ptr] <= wr_data_i;
        end
    end

endmodule

/* logic/sigma_delta_dac.sv */
// ======================================================================
// Stereo delta-sigma DAC
// Clock enable every CEN_PERIOD cycles of clk_dac, a hold counter that
// keeps each word for HOLD_TICKS ticks, and one first-order modulator
// per channel driving a pulse-density output
// ======================================================================

`include "dac_macros.svh"

module sigma_delta_dac (
    input  logic                clk_dac,
    input  logic                rst,
    input  dac_pkg::dac_pair_t  word_i,
    input  logic                word_valid_i,
    output logic                word_ready_o,
    output logic                pwm_left_o,
    output logic                pwm_right_o
);

    localparam int DAC_N  = `DAC_W;
    localparam int CEN_N  = `CEN_PERIOD;
    localparam int HOLD_N = `HOLD_TICKS;
    localparam int HOLD_W = $clog2(HOLD_N);

    // First tick lands CEN_PERIOD-1 cycles after reset
    localparam logic [CEN_N-1:0]  CEN_INIT  = {{(CEN_N-1){1'b0}}, 1'b1} << (CEN_N - 2);
    localparam logic [HOLD_W-1:0] HOLD_LAST = HOLD_W'(HOLD_N - 1);

    logic [CEN_N-1:0]     cen_sr;
    logic                 cen;
    dac_pkg::dac_state_e  state;
    logic [HOLD_W-1:0]    hold_cnt;
    logic                 last_tick;
    logic                 take;
    dac_pkg::dac_pair_t   held;
    dac_pkg::dac_pair_t   acc;
    logic [DAC_N:0]       sum_left;
    logic [DAC_N:0]       sum_right;

    // Accumulator plus word, carry on top
    function automatic logic [DAC_N:0] mod_step(
        input logic [DAC_N-1:0] acc_in,
        input logic [DAC_N-1:0] word
    );
        mod_step = {1'b0, acc_in} + {1'b0, word};
    endfunction

    // Rotating one-hot enable
    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            cen_sr <= CEN_INIT;
        end else begin
            cen_sr <= {cen_sr[CEN_N-2:0], cen_sr[CEN_N-1]};
        end
    end

    assign cen = cen_sr[0];

    // Next word wanted when idle or on the final tick of a hold
    assign last_tick    = cen && (state == dac_pkg::DAC_RUN) && (hold_cnt == HOLD_LAST);
    assign word_ready_o = (state == dac_pkg::DAC_IDLE) || last_tick;
    assign take         = word_valid_i && word_ready_o;

    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            state    <= dac_pkg::DAC_IDLE;
            hold_cnt <= '0;
        end else begin
            case (state)
                dac_pkg::DAC_IDLE: begin
                    if (take) begin
                        state    <= dac_pkg::DAC_RUN;
                        hold_cnt <= '0;
                    end
                end
                dac_pkg::DAC_RUN: begin
                    if (last_tick) begin
                        hold_cnt <= '0;
                        // Back-to-back words keep running with no gap
                        if (!take) begin
                            state <= dac_pkg::DAC_IDLE;
                        end
                    end else if (cen) begin
                        hold_cnt <= hold_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= dac_pkg::DAC_IDLE;
                end
            endcase
        end
    end

    // Sample under conversion
    always_ff @(posedge clk_dac) begin
        if (take) begin
            held <= word_i;
        end
    end

    assign sum_left  = mod_step(acc.left, held.left);
    assign sum_right = mod_step(acc.right, held.right);

    // Modulators step only while running.
    // Each carry is shown for one full tick period, so the final
    // carry of a stream clears on the first idle tick
    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            acc         <= '0;
            pwm_left_o  <= 1'b0;
            pwm_right_o <= 1'b0;
        end else if (cen) begin
            if (state == dac_pkg::DAC_RUN) begin
                acc.left    <= sum_left[DAC_N-1:0];
                acc.right   <= sum_right[DAC_N-1:0];
                pwm_left_o  <= sum_left[DAC_N];
                pwm_right_o <= sum_right[DAC_N];
            end else begin
                pwm_left_o  <= 1'b0;
                pwm_right_o <= 1'b0;
            end
        end
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the audio DAC testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
    -f flist.f --top-module audio_dac_tb -o audio_dac_sim > build.log 2>&1 \
    && ./obj_dir/audio_dac_sim > "$LOG" 2>&1 \
    || { echo "Build or simulation did not complete"; cat build.log; exit 1; }

cat "$LOG"

grep -q "STATUS: FAIL" "$LOG" \
    && { echo "Simulation reported failures"; exit 1; } \
    || { echo "Simulation finished cleanly"; exit 0; }

/* test/audio_dac_tb.sv */
// ======================================================================
// Audio DAC testbench
// Streams stereo PCM records from the stimulus file into the DUT,
// measures pulse density on both outputs and checks high-tick totals
// against the file and against a model of the modulator rule
// ======================================================================

`include "dac_macros.svh"

module audio_dac_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int PCM_N    = `PCM_W;
    localparam int DAC_N    = `DAC_W;
    localparam int CEN_N    = `CEN_PERIOD;
    localparam int HOLD_N   = `HOLD_TICKS;
    localparam int PUSH_MAX = 1024;
    localparam int RECORDS  = 5;

    logic               clk_dac;
    logic               rst;
    dac_pkg::pcm_pair_t sample_i;
    logic               sample_valid_i;
    logic               sample_ready_o;
    logic               snd_pwm_left_o;
    logic               snd_pwm_right_o;

    int  seed = 32'h6b5a;
    int  left_high;
    int  right_high;
    int  words_taken;
    int  tests_passed;
    int  tests_failed;
    bit  test_error;
    bit  timed_out;
    bit  saw_stall;

    // Model accumulators carried from test to test
    longint model_acc_left;
    longint model_acc_right;

    logic [PCM_N-1:0] left_q[$];
    logic [PCM_N-1:0] right_q[$];

    audio_dac_top #(
        .SIGNED_SND      ( 1'b1            )
    ) audio_dac_top_inst (
        .clk_dac         ( clk_dac         ),
        .rst             ( rst             ),
        .sample_i        ( sample_i        ),
        .sample_valid_i  ( sample_valid_i  ),
        .sample_ready_o  ( sample_ready_o  ),
        .snd_pwm_left_o  ( snd_pwm_left_o  ),
        .snd_pwm_right_o ( snd_pwm_right_o )
    );

    initial begin
        clk_dac = 1'b0;
        forever #2 clk_dac = ~clk_dac;
    end

    // High cycles per channel and words loaded by the consumer, sampled mid-cycle
    always @(negedge clk_dac) begin
        if (!rst) begin
            if (snd_pwm_left_o) begin
                left_high <= left_high + 1;
            end
            if (snd_pwm_right_o) begin
                right_high <= right_high + 1;
            end
            if (audio_dac_top_inst.fifo_valid && audio_dac_top_inst.fifo_ready) begin
                words_taken <= words_taken + 1;
            end
        end
    end

    // Sign flip and padding with one zero above and zeros below
    function automatic longint padded_word(input logic [PCM_N-1:0] snd);
        logic [PCM_N-1:0] offset;
        offset = snd ^ {1'b1, {(PCM_N-1){1'b0}}};
        padded_word = longint'(offset) << (DAC_N - PCM_N - 1);
    endfunction

    // Expected carries of the queued samples and the new model accumulators
    task automatic model_totals(output int exp_left, output int exp_right);
        longint sum_left;
        longint sum_right;
        longint mask;
        mask      = (longint'(1) << DAC_N) - 1;
        sum_left  = model_acc_left;
        sum_right = model_acc_right;
        foreach (left_q[i]) begin
            sum_left  += padded_word(left_q[i]) * HOLD_N;
            sum_right += padded_word(right_q[i]) * HOLD_N;
        end
        exp_left        = int'(sum_left >> DAC_N);
        exp_right       = int'(sum_right >> DAC_N);
        model_acc_left  = sum_left & mask;
        model_acc_right = sum_right & mask;
    endtask

    task automatic idle_cycles(input int cycles);
        repeat (cycles) begin
            @(posedge clk_dac);
            #1;
        end
    endtask

    // Holds the sample on the stream until the DUT takes it
    task automatic push_sample(input logic [PCM_N-1:0] l, input logic [PCM_N-1:0] r);
        int waited;
        bit done;
        waited         = 0;
        done           = 1'b0;
        sample_i.left  = l;
        sample_i.right = r;
        sample_valid_i = 1'b1;
        while (!done && !timed_out) begin
            @(negedge clk_dac);
            if (sample_ready_o) begin
                done = 1'b1;
            end else begin
                saw_stall = 1'b1;
                waited++;
                if (waited > PUSH_MAX) begin
                    $display("Timeout at %0t: the input stream never became ready", $time);
                    timed_out = 1'b1;
                end
            end
            @(posedge clk_dac);
            #1;
        end
        sample_valid_i = 1'b0;
    endtask

    // Consumer idle with nothing left in the formatter or the FIFO
    task automatic wait_drained(input int limit);
        int waited;
        bit drained;
        waited  = 0;
        drained = 1'b0;
        while (!drained && !timed_out) begin
            @(negedge clk_dac);
            if (audio_dac_top_inst.u_dac.state == dac_pkg::DAC_IDLE &&
                !audio_dac_top_inst.fifo_valid && !audio_dac_top_inst.fmt_valid) begin
                drained = 1'b1;
            end else begin
                waited++;
                if (waited > limit) begin
                    $display("Timeout at %0t: the DUT did not drain its samples", $time);
                    timed_out = 1'b1;
                end
            end
        end
        // Final carry stays up until the next enable tick
        repeat (CEN_N + 1) @(posedge clk_dac);
        #1;
    endtask

    task automatic idle_window(input int cycles);
        bit bad;
        bad = 1'b0;
        repeat (cycles) begin
            @(negedge clk_dac);
            if (!bad && (snd_pwm_left_o || snd_pwm_right_o)) begin
                $display("** Error at %0t: pwm output high with no input", $time);
                bad        = 1'b1;
                test_error = 1'b1;
            end
            if (!bad && !sample_ready_o) begin
                $display("** Error at %0t: sample_ready_o low while idle", $time);
                bad        = 1'b1;
                test_error = 1'b1;
            end
        end
        @(posedge clk_dac);
        #1;
    endtask

    task automatic check_total(input int test_id, input string side, input int cycles,
                               input int expected);
        if (cycles % CEN_N != 0) begin
            $display("** Error at %0t: test %0d %s high for %0d cycles, not whole ticks",
                     $time, test_id, side, cycles);
            test_error = 1'b1;
        end
        if (cycles / CEN_N != expected) begin
            $display("** Error at %0t: test %0d %s ticks %0d, expected %0d",
                     $time, test_id, side, cycles / CEN_N, expected);
            test_error = 1'b1;
        end
    endtask

    task automatic run_record(input int fd, input int test_id, input int count);
        int               code;
        int               gap;
        int               file_left;
        int               file_right;
        int               model_left;
        int               model_right;
        int               start_left;
        int               start_right;
        int               start_taken;
        logic [PCM_N-1:0] l;
        logic [PCM_N-1:0] r;
        left_q.delete();
        right_q.delete();
        test_error = 1'b0;
        saw_stall  = 1'b0;
        for (int i = 0; i < count; i++) begin
            code = $fscanf(fd, "%h %h", l, r);
            if (code != 2) begin
                $display("Test %0d has a sample line that could not be read", test_id);
                test_error = 1'b1;
            end
            left_q.push_back(l);
            right_q.push_back(r);
        end
        code = $fscanf(fd, "%d %d", file_left, file_right);
        if (code != 2) begin
            $display("Test %0d has no expected totals line", test_id);
            test_error = 1'b1;
        end
        model_totals(model_left, model_right);
        if (model_left != file_left || model_right != file_right) begin
            $display("** Error at %0t: test %0d file totals %0d/%0d, model gives %0d/%0d",
                     $time, test_id, file_left, file_right, model_left, model_right);
            test_error = 1'b1;
        end
        start_left  = left_high;
        start_right = right_high;
        start_taken = words_taken;
        if (count == 0) begin
            idle_window((test_id == 1) ? 100 : 200);
        end else begin
            for (int i = 0; i < count && !timed_out; i++) begin
                // Random idle gaps only in the burst test
                if (test_id == 4) begin
                    gap = $random(seed) & 3;
                    idle_cycles(gap);
                end
                push_sample(left_q[i], right_q[i]);
            end
            wait_drained(count * CEN_N * HOLD_N + 200);
        end
        check_total(test_id, "left", left_high - start_left, file_left);
        check_total(test_id, "right", right_high - start_right, file_right);
        if (words_taken - start_taken != count) begin
            $display("Test %0d: %0d of %0d samples reached the consumer", test_id,
                     words_taken - start_taken, count);
            test_error = 1'b1;
        end
        if (test_id == 4 && !saw_stall) begin
            $display("Test 4: sample_ready_o never went low during the burst");
            test_error = 1'b1;
        end
        if (timed_out) begin
            test_error = 1'b1;
        end
        if (test_error) begin
            tests_failed++;
            $display("Test %0d failed", test_id);
        end else begin
            tests_passed++;
            $display("Test %0d ok, %0d samples, ticks %0d/%0d",
                     test_id, count, file_left, file_right);
        end
    endtask

    initial begin
        int    fd;
        int    code;
        int    test_id;
        int    sample_count;
        bit    reading;
        string header;
        $timeformat(-9, 0, " ns", 0);
        rst             = 1'b1;
        sample_i        = '0;
        sample_valid_i  = 1'b0;
        model_acc_left  = 0;
        model_acc_right = 0;
        tests_passed    = 0;
        tests_failed    = 0;
        timed_out       = 1'b0;
        repeat (3) @(posedge clk_dac);
        #1;
        rst = 1'b0;
        fd = $fopen("test/dac_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file test/dac_stim.txt");
            tests_failed++;
        end else begin
            // Two column description lines at the top
            code    = $fgets(header, fd);
            code    = $fgets(header, fd);
            reading = 1'b1;
            while (reading && !timed_out) begin
                code = $fscanf(fd, "%d %d", test_id, sample_count);
                if (code != 2) begin
                    reading = 1'b0;
                end else begin
                    run_record(fd, test_id, sample_count);
                end
            end
            $fclose(fd);
            if (tests_passed + tests_failed != RECORDS) begin
                $display("The stimulus file gave %0d tests where %0d were expected",
                         tests_passed + tests_failed, RECORDS);
                tests_failed++;
            end
        end
        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* test/dac_stim.txt */
# Record: test_id sample_count, then sample_count lines of raw left right PCM (hex),
# then the expected high-tick totals left right (decimal)
1 0
0 0
2 3
8000 7fff
8000 7fff
7fff 8000
7 15
3 5
9000 7fff
b000 8001
2000 0000
8800 c321
4400 a468
14 16
4 12
9000 7fff
a000 8000
b000 ffff
c000 0001
d000 9234
e000 6dcb
f000 8100
0000 7f00
1000 d555
2000 2aaa
3000 8f0f
4000 70f0
39 48
5 0
0 0
